//--- verilog/snes_load_pkg.sv
package snes_load_pkg;

  // download stream, byte addressed
  parameter int IOCTL_ADDR_W = 25;
  // one download word carries two bytes
  parameter int IOCTL_DATA_W = 16;

  // core work-ram byte address, 128k
  parameter int WRAM_ADDR_W = 17;

  // rom and save-ram address masks handed to the core
  parameter int MASK_W = 24;

  // copier header in front of some images
  parameter int HEADER_BYTES = 512;

  // countdown after the end of a download
  parameter int SETTLE_CYCLES = 6;

  // clear steps once every four clocks
  parameter int CLEAR_DIV_W = 2;

  typedef logic [IOCTL_ADDR_W-1:0] ioctl_addr_t;
  typedef logic [MASK_W-1:0] mask_t;
  typedef logic [WRAM_ADDR_W-1:0] wram_addr_t;

  // size code as stored in the first image byte
  typedef logic [3:0] size_code_t;

  // 4 mbyte rom assumed when the image gives no size
  parameter size_code_t DEFAULT_ROM_SIZE = 4'hC;

  // work-ram power-on contents
  typedef enum logic [1:0] {
    // 66/99 checkerboard
    FILL_CHECKER = 2'd0,
    // ff/00 stripes
    FILL_STRIPE  = 2'd1,
    FILL_55      = 2'd2,
    FILL_FF      = 2'd3
  } fill_pattern_e;

  // cartridge load tracking
  typedef enum logic [1:0] {
    LD_IDLE     = 2'd0,
    // image bytes streaming in
    LD_DOWNLOAD = 2'd1,
    // waiting for the size codes to settle
    LD_SETTLE   = 2'd2
  } load_state_e;

endpackage

//--- verilog/cart_load_tracker.sv
`timescale 1ns/1ps

module cart_load_tracker (
  input  logic                                    clk_sys,
  input  logic                                    reset,
  input  logic                                    ioctl_download,
  input  logic                                    ioctl_wr,
  input  snes_load_pkg::ioctl_addr_t              ioctl_addr,
  input  logic [snes_load_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
  input  logic [31:0]                             rom_file_size,
  output snes_load_pkg::ioctl_addr_t              cart_addr,
  output snes_load_pkg::mask_t                    rom_mask,
  output snes_load_pkg::mask_t                    ram_mask,
  output snes_load_pkg::size_code_t               sram_size,
  output logic                                    load_busy
);

  import snes_load_pkg::*;

  localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

  load_state_e state;
  logic [CNT_W-1:0] settle_cnt;
  logic dl_q;
  logic dl_fall;
  logic has_header;
  size_code_t rom_code;
  size_code_t ram_code;

  // file size not a multiple of 1k means a 512 byte copier header
  assign has_header = rom_file_size[9];
  assign cart_addr = has_header ? ioctl_addr - ioctl_addr_t'(HEADER_BYTES) : ioctl_addr;

  // end of download seen through the registered copy
  assign dl_fall = dl_q & ~ioctl_download;

  // state covers the edge cycle and the whole countdown
  assign load_busy = ioctl_download | (state != LD_IDLE);

  // size codes from the first image byte
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      rom_code <= '0;
      ram_code <= '0;
    end else if (ioctl_download && ioctl_wr && cart_addr == '0) begin
      if (ioctl_dout[7:0] != 8'h00) begin
        // low nibble rom, high nibble save ram
        rom_code <= ioctl_dout[3:0];
        ram_code <= ioctl_dout[7:4];
      end else begin
        rom_code <= DEFAULT_ROM_SIZE;
        ram_code <= '0;
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      state <= LD_IDLE;
      settle_cnt <= '0;
      dl_q <= 1'b0;
      rom_mask <= '0;
      ram_mask <= '0;
      sram_size <= '0;
    end else begin
      dl_q <= ioctl_download;
      case (state)
        LD_IDLE: begin
          if (ioctl_download) begin
            state <= LD_DOWNLOAD;
          end
        end
        LD_DOWNLOAD: begin
          if (dl_fall) begin
            state <= LD_SETTLE;
            settle_cnt <= CNT_W'(SETTLE_CYCLES);
          end
        end
        LD_SETTLE: begin
          if (dl_fall) begin
            // another short download, start over
            settle_cnt <= CNT_W'(SETTLE_CYCLES);
          end else if (settle_cnt == CNT_W'(1)) begin
            // masks ready before the core leaves reset
            rom_mask <= (mask_t'(1024) << rom_code) - mask_t'(1);
            ram_mask <= (ram_code == '0) ? '0 : (mask_t'(1024) << ram_code) - mask_t'(1);
            sram_size <= ram_code;
            settle_cnt <= '0;
            state <= LD_IDLE;
          end else begin
            settle_cnt <= settle_cnt - CNT_W'(1);
          end
        end
        default: state <= LD_IDLE;
      endcase
    end
  end

  // countdown stays inside its start value
  a_settle_range: assert property (
    @(posedge clk_sys) disable iff (!reset) settle_cnt <= CNT_W'(SETTLE_CYCLES)
  );

endmodule

//--- verilog/ram_clearer.sv
`timescale 1ns/1ps

module ram_clearer #(
  parameter int CLEAR_ADDR_W = 17
) (
  input  logic                          clk_sys,
  input  logic                          reset,
  input  logic                          ioctl_download,
  input  snes_load_pkg::fill_pattern_e  fill_pattern,
  output logic                          clearing,
  output logic [CLEAR_ADDR_W-1:0]       fill_addr,
  output logic [7:0]                    fill_data
);

  import snes_load_pkg::*;

  logic dl_q;
  logic dl_rise;
  logic [CLEAR_DIV_W-1:0] clear_div;
  wram_addr_t fill_ext;

  assign dl_rise = ioctl_download & ~dl_q;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      dl_q <= 1'b0;
      clear_div <= '0;
      clearing <= 1'b0;
      fill_addr <= '0;
    end else begin
      dl_q <= ioctl_download;
      // free running, not aligned to the start of the clear
      clear_div <= clear_div + CLEAR_DIV_W'(1);
      if (dl_rise) begin
        // new download restarts the sweep from zero
        clearing <= 1'b1;
        fill_addr <= '0;
      end else if (clearing) begin
        if (&fill_addr) begin
          // last address done, park at zero
          clearing <= 1'b0;
          fill_addr <= '0;
        end else if (clear_div == '0) begin
          fill_addr <= fill_addr + CLEAR_ADDR_W'(1);
        end
      end
    end
  end

  // upper address bits read as zero for short sweeps
  assign fill_ext = wram_addr_t'(fill_addr);

  always_comb begin
    case (fill_pattern)
      FILL_CHECKER: fill_data = (fill_ext[8] ^ fill_ext[2]) ? 8'h66 : 8'h99;
      FILL_STRIPE:  fill_data = (fill_ext[9] ^ fill_ext[0]) ? 8'hFF : 8'h00;
      FILL_55:      fill_data = 8'h55;
      FILL_FF:      fill_data = 8'hFF;
      default:      fill_data = 8'hFF;
    endcase
  end

  // sweep always starts from address zero
  a_fill_parked: assert property (
    @(posedge clk_sys) disable iff (!reset) !clearing |-> fill_addr == '0
  );

endmodule

//--- verilog/core_gate.sv
`timescale 1ns/1ps

module core_gate #(
  parameter int CLEAR_ADDR_W = 17
) (
  input  logic                                    clk_sys,
  input  logic                                    reset,
  input  logic                                    core_reset,
  input  logic                                    load_busy,
  input  logic                                    clearing,
  input  logic [CLEAR_ADDR_W-1:0]                 fill_addr,
  input  logic [7:0]                              fill_data,
  input  snes_load_pkg::wram_addr_t               wram_addr,
  input  logic [7:0]                              wram_d,
  input  logic                                    wram_ce_n,
  input  logic                                    wram_we_n,
  input  logic                                    wram_oe_n,
  input  logic [15:0]                             mem_dout,
  output logic [7:0]                              wram_q,
  output logic [snes_load_pkg::WRAM_ADDR_W-2:0]   mem_addr,
  output logic [15:0]                             mem_din,
  output logic                                    mem_we,
  output logic                                    mem_re,
  output logic                                    mem_ub,
  output logic                                    mem_lb,
  output logic                                    core_reset_n
);

  import snes_load_pkg::*;

  localparam int GATE_DIV_W = 2;

  logic [GATE_DIV_W-1:0] gate_div;
  logic hold;
  wram_addr_t eff_addr;
  logic core_wr;
  logic core_rd;

  // any of these keeps the core stopped
  assign hold = core_reset | load_busy | clearing;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      gate_div <= '0;
      core_reset_n <= 1'b0;
    end else begin
      gate_div <= gate_div + GATE_DIV_W'(1);
      // one sample per four clocks
      if (gate_div == GATE_DIV_W'(2)) begin
        core_reset_n <= ~hold;
      end
    end
  end

  // active low strobes from the core
  assign core_wr = ~wram_ce_n & ~wram_we_n;
  assign core_rd = ~wram_ce_n & ~wram_oe_n;

  // clearer owns the port while it runs
  assign eff_addr = clearing ? wram_addr_t'(fill_addr) : wram_addr;

  always_comb begin
    if (clearing) begin
      // same byte in both lanes, lane select picks one
      mem_din = {fill_data, fill_data};
      mem_we = 1'b1;
      mem_re = 1'b0;
    end else begin
      // odd byte address goes in the upper lane
      mem_din = eff_addr[0] ? {wram_d, 8'h00} : {8'h00, wram_d};
      mem_we = core_wr;
      mem_re = core_rd;
    end
  end

  // byte address to word address
  assign mem_addr = eff_addr[WRAM_ADDR_W-1:1];
  assign mem_ub = eff_addr[0];
  assign mem_lb = ~eff_addr[0];

  assign wram_q = eff_addr[0] ? mem_dout[15:8] : mem_dout[7:0];

  // core never strobes write and read together, clear never reads
  a_we_re_excl: assert property (
    @(posedge clk_sys) disable iff (!reset) !(mem_we && mem_re)
  );

endmodule

//--- verilog/snes_load_ctrl.sv
`timescale 1ns/1ps

module snes_load_ctrl #(
  parameter int CLEAR_ADDR_W = 17
) (
  input  logic                                    clk_sys,
  input  logic                                    reset,
  input  logic                                    core_reset,
  // rom download stream
  input  logic                                    ioctl_download,
  input  logic                                    ioctl_wr,
  input  snes_load_pkg::ioctl_addr_t              ioctl_addr,
  input  logic [snes_load_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
  input  logic [31:0]                             rom_file_size,
  input  snes_load_pkg::fill_pattern_e            fill_pattern,
  // core work-ram request
  input  snes_load_pkg::wram_addr_t               wram_addr,
  input  logic [7:0]                              wram_d,
  input  logic                                    wram_ce_n,
  input  logic                                    wram_we_n,
  input  logic                                    wram_oe_n,
  output logic [7:0]                              wram_q,
  // 16-bit memory port
  output logic [snes_load_pkg::WRAM_ADDR_W-2:0]   mem_addr,
  output logic [15:0]                             mem_din,
  output logic                                    mem_we,
  output logic                                    mem_re,
  output logic                                    mem_ub,
  output logic                                    mem_lb,
  input  logic [15:0]                             mem_dout,
  // load results
  output snes_load_pkg::ioctl_addr_t              cart_addr,
  output snes_load_pkg::mask_t                    rom_mask,
  output snes_load_pkg::mask_t                    ram_mask,
  output snes_load_pkg::size_code_t               sram_size,
  output logic                                    core_reset_n
);

  logic load_busy;
  logic clearing;
  logic [CLEAR_ADDR_W-1:0] fill_addr;
  logic [7:0] fill_data;

  // header skip, size codes, mask latch
  cart_load_tracker u_cart_load_tracker (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .ioctl_download (ioctl_download),
    .ioctl_wr       (ioctl_wr),
    .ioctl_addr     (ioctl_addr),
    .ioctl_dout     (ioctl_dout),
    .rom_file_size  (rom_file_size),
    .cart_addr      (cart_addr),
    .rom_mask       (rom_mask),
    .ram_mask       (ram_mask),
    .sram_size      (sram_size),
    .load_busy      (load_busy)
  );

  // work-ram wipe on download start
  ram_clearer #(
    .CLEAR_ADDR_W (CLEAR_ADDR_W)
  ) u_ram_clearer (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .ioctl_download (ioctl_download),
    .fill_pattern   (fill_pattern),
    .clearing       (clearing),
    .fill_addr      (fill_addr),
    .fill_data      (fill_data)
  );

  // core reset hold and memory port steering
  core_gate #(
    .CLEAR_ADDR_W (CLEAR_ADDR_W)
  ) u_core_gate (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .core_reset   (core_reset),
    .load_busy    (load_busy),
    .clearing     (clearing),
    .fill_addr    (fill_addr),
    .fill_data    (fill_data),
    .wram_addr    (wram_addr),
    .wram_d       (wram_d),
    .wram_ce_n    (wram_ce_n),
    .wram_we_n    (wram_we_n),
    .wram_oe_n    (wram_oe_n),
    .mem_dout     (mem_dout),
    .wram_q       (wram_q),
    .mem_addr     (mem_addr),
    .mem_din      (mem_din),
    .mem_we       (mem_we),
    .mem_re       (mem_re),
    .mem_ub       (mem_ub),
    .mem_lb       (mem_lb),
    .core_reset_n (core_reset_n)
  );

endmodule

//--- verification/tb_snes_load_ctrl.sv
`timescale 1ns/1ps

module tb_snes_load_ctrl;

  import snes_load_pkg::*;

  localparam int CLEAR_W = 10;
  localparam int NUM_LOADS = 5;
  localparam int CORE_OPS = 48;
  // clear sweep plus the longest download, header and gaps included
  localparam int LOAD_CYCLES = 4 * (1 << CLEAR_W) + 5 * 310 + 100;
  localparam int WATCHDOG_CYCLES = NUM_LOADS * (LOAD_CYCLES + 2 * CORE_OPS + 40) + 100;

  logic clk_sys;
  logic reset;
  logic core_reset;
  logic ioctl_download;
  logic ioctl_wr;
  ioctl_addr_t ioctl_addr;
  logic [15:0] ioctl_dout;
  logic [31:0] rom_file_size;
  fill_pattern_e fill_pattern;
  wram_addr_t wram_addr;
  logic [7:0] wram_d;
  logic wram_ce_n;
  logic wram_we_n;
  logic wram_oe_n;
  logic [7:0] wram_q;
  logic [15:0] mem_addr;
  logic [15:0] mem_din;
  logic mem_we;
  logic mem_re;
  logic mem_ub;
  logic mem_lb;
  logic [15:0] mem_dout;
  ioctl_addr_t cart_addr;
  mask_t rom_mask;
  mask_t ram_mask;
  size_code_t sram_size;
  logic core_reset_n;

  // 64k word memory behind the port
  logic [15:0] mem [0:65535];
  logic [31:0] rng;
  logic in_load;
  logic clear_seen;
  int err_count;
  wram_addr_t wr_addr_q[$];
  logic [7:0] wr_data_q[$];

  snes_load_ctrl #(
    .CLEAR_ADDR_W (CLEAR_W)
  ) u_snes_load_ctrl (
    .clk_sys (clk_sys), .reset (reset), .core_reset (core_reset),
    .ioctl_download (ioctl_download), .ioctl_wr (ioctl_wr), .ioctl_addr (ioctl_addr),
    .ioctl_dout (ioctl_dout), .rom_file_size (rom_file_size), .fill_pattern (fill_pattern),
    .wram_addr (wram_addr), .wram_d (wram_d), .wram_ce_n (wram_ce_n),
    .wram_we_n (wram_we_n), .wram_oe_n (wram_oe_n), .wram_q (wram_q),
    .mem_addr (mem_addr), .mem_din (mem_din), .mem_we (mem_we), .mem_re (mem_re),
    .mem_ub (mem_ub), .mem_lb (mem_lb), .mem_dout (mem_dout),
    .cart_addr (cart_addr), .rom_mask (rom_mask), .ram_mask (ram_mask),
    .sram_size (sram_size), .core_reset_n (core_reset_n)
  );

  assign mem_dout = mem[mem_addr];

  initial begin
    clk_sys = 1'b0;
    forever #20 clk_sys = ~clk_sys;
  end

  // xorshift32 on the shared state
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // expected power-on byte for one work-ram address
  function automatic logic [7:0] fill_byte(fill_pattern_e pat, wram_addr_t a);
    case (pat)
      FILL_CHECKER: return (a[8] != a[2]) ? 8'h66 : 8'h99;
      FILL_STRIPE:  return (a[9] != a[0]) ? 8'hFF : 8'h00;
      FILL_55:      return 8'h55;
      default:      return 8'hFF;
    endcase
  endfunction

  // 1k shifted by the size code, minus one, cut to mask width
  function automatic mask_t size_mask(size_code_t code);
    logic [31:0] full;
    full = (32'd1024 << code) - 32'd1;
    return full[MASK_W-1:0];
  endfunction

  task automatic mismatch(string name, logic [31:0] exp, logic [31:0] act);
    err_count++;
    $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(string msg);
    err_count++;
    $display("ERROR: %s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  // memory model and per-cycle checks, mid cycle where all is settled
  always @(negedge clk_sys) begin
    ioctl_addr_t exp_cart;
    wram_addr_t byte_addr;
    logic [7:0] lane;
    byte_addr = {mem_addr, mem_ub};
    lane = mem_ub ? mem_din[15:8] : mem_din[7:0];
    if (mem_we && mem_ub) begin
      mem[mem_addr][15:8] = mem_din[15:8];
    end
    if (mem_we && mem_lb) begin
      mem[mem_addr][7:0] = mem_din[7:0];
    end
    // copier header skip
    if (ioctl_download) begin
      exp_cart = rom_file_size[9] ? ioctl_addr - ioctl_addr_t'(512) : ioctl_addr;
      assert (cart_addr == exp_cart)
        else mismatch("cart_addr", 32'(exp_cart), 32'(cart_addr));
    end
    // core idle during a load, so any write is a fill write
    if (in_load && mem_we) begin
      clear_seen = 1'b1;
      assert (byte_addr < wram_addr_t'(1 << CLEAR_W))
        else abort_run("clear write outside the cleared range");
      assert (lane == fill_byte(fill_pattern, byte_addr))
        else mismatch("clear fill byte", 32'(fill_byte(fill_pattern, byte_addr)), 32'(lane));
    end
    if (in_load && (core_reset || ioctl_download || mem_we)) begin
      assert (!core_reset_n)
        else abort_run("core_reset_n high while core_reset, download or clear is active");
    end
  end

  // one download with random header, first byte, gaps and pattern, then result checks
  task automatic run_load();
    logic [31:0] r;
    logic hdr;
    logic [7:0] first_byte;
    int nwords;
    int first_idx;
    int wait_cnt;
    size_code_t rom_code;
    size_code_t ram_code;
    mask_t exp_ram;
    logic [15:0] exp_word;
    r = next_rand();
    hdr = r[0];
    first_byte = (r[3:2] == 2'b00) ? 8'h00 : r[15:8];
    nwords = 16 + int'(r[20:16]);
    first_idx = hdr ? 256 : 0;
    @(posedge clk_sys);
    #2;
    core_reset = 1'b1;
    fill_pattern = fill_pattern_e'(r[23:22]);
    r = next_rand();
    rom_file_size = {r[31:10], hdr, r[8:0]};
    wait_cnt = 0;
    @(negedge clk_sys);
    while (core_reset_n) begin
      @(negedge clk_sys);
      wait_cnt++;
      assert (wait_cnt <= 8) else abort_run("core_reset_n did not fall on core_reset");
    end
    in_load = 1'b1;
    clear_seen = 1'b0;
    @(posedge clk_sys);
    #2;
    ioctl_download = 1'b1;
    for (int i = 0; i < first_idx + nwords; i++) begin
      r = next_rand();
      repeat (int'(r[1:0])) @(posedge clk_sys);
      @(posedge clk_sys);
      #2;
      ioctl_wr = 1'b1;
      ioctl_addr = ioctl_addr_t'(2 * i);
      ioctl_dout = (i == first_idx) ? {r[15:8], first_byte} : r[31:16];
      // external reset released while the download still holds the core
      if (i == 2) begin
        core_reset = 1'b0;
      end
      @(posedge clk_sys);
      #2;
      ioctl_wr = 1'b0;
    end
    repeat (2) @(posedge clk_sys);
    #2;
    ioctl_download = 1'b0;
    // size codes from the first image byte
    rom_code = (first_byte != 8'h00) ? first_byte[3:0] : DEFAULT_ROM_SIZE;
    ram_code = (first_byte != 8'h00) ? first_byte[7:4] : 4'h0;
    exp_ram = (ram_code == 4'h0) ? '0 : size_mask(ram_code);
    // clear outlasts the download, its last write marks the end
    @(negedge clk_sys);
    while (mem_we) @(negedge clk_sys);
    assert (clear_seen) else abort_run("no clear writes seen during the download");
    wait_cnt = 0;
    while (!core_reset_n) begin
      @(negedge clk_sys);
      wait_cnt++;
      assert (wait_cnt <= 16) else abort_run("core_reset_n not released after the clear");
    end
    in_load = 1'b0;
    assert (rom_mask == size_mask(rom_code))
      else mismatch("rom_mask", 32'(size_mask(rom_code)), 32'(rom_mask));
    assert (ram_mask == exp_ram) else mismatch("ram_mask", 32'(exp_ram), 32'(ram_mask));
    assert (sram_size == ram_code) else mismatch("sram_size", 32'(ram_code), 32'(sram_size));
    for (int w = 0; w < (1 << CLEAR_W) / 2; w++) begin
      exp_word = {fill_byte(fill_pattern, wram_addr_t'(2 * w + 1)),
                  fill_byte(fill_pattern, wram_addr_t'(2 * w))};
      assert (mem[w] == exp_word) else mismatch("cleared word", 32'(exp_word), 32'(mem[w]));
    end
  endtask

  // random core writes, reads only of bytes written in this round
  task automatic run_core_ops();
    logic [31:0] r;
    wram_addr_t addr;
    logic [7:0] data;
    logic [15:0] exp_din;
    int idx;
    wr_addr_q.delete();
    wr_data_q.delete();
    for (int k = 0; k < CORE_OPS; k++) begin
      r = next_rand();
      @(posedge clk_sys);
      #2;
      if (wr_addr_q.size() == 0 || r[0]) begin
        addr = r[25:9];
        data = r[8:1];
        wram_addr = addr;
        wram_d = data;
        wram_ce_n = 1'b0;
        wram_we_n = 1'b0;
        @(negedge clk_sys);
        exp_din = addr[0] ? {data, 8'h00} : {8'h00, data};
        assert (mem_we && !mem_re) else abort_run("core write missing on the memory port");
        assert (mem_addr == addr[16:1])
          else mismatch("write word address", 32'(addr[16:1]), 32'(mem_addr));
        assert (mem_ub == addr[0] && mem_lb == !addr[0])
          else mismatch("write lanes", 32'({addr[0], !addr[0]}), 32'({mem_ub, mem_lb}));
        assert (mem_din == exp_din) else mismatch("write data", 32'(exp_din), 32'(mem_din));
        wr_addr_q.push_back(addr);
        wr_data_q.push_back(data);
      end else begin
        idx = int'(r[15:0]) % wr_addr_q.size();
        addr = wr_addr_q[idx];
        // latest write to that byte wins
        for (int j = 0; j < wr_addr_q.size(); j++) begin
          if (wr_addr_q[j] == addr) begin
            data = wr_data_q[j];
          end
        end
        wram_addr = addr;
        wram_ce_n = 1'b0;
        wram_oe_n = 1'b0;
        @(negedge clk_sys);
        assert (mem_re && !mem_we) else abort_run("core read missing on the memory port");
        assert (mem_addr == addr[16:1])
          else mismatch("read word address", 32'(addr[16:1]), 32'(mem_addr));
        assert (wram_q == data) else mismatch("read data", 32'(data), 32'(wram_q));
      end
      @(posedge clk_sys);
      #2;
      wram_ce_n = 1'b1;
      wram_we_n = 1'b1;
      wram_oe_n = 1'b1;
    end
  endtask

  initial begin
    reset = 1'b0;
    core_reset = 1'b0;
    ioctl_download = 1'b0;
    ioctl_wr = 1'b0;
    ioctl_addr = '0;
    ioctl_dout = '0;
    rom_file_size = '0;
    fill_pattern = FILL_FF;
    wram_addr = '0;
    wram_d = '0;
    wram_ce_n = 1'b1;
    wram_we_n = 1'b1;
    wram_oe_n = 1'b1;
    in_load = 1'b0;
    clear_seen = 1'b0;
    err_count = 0;
    rng = 32'd99372;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 16'(i) ^ 16'hA55A;
    end
    repeat (4) @(posedge clk_sys);
    #2;
    reset = 1'b1;
    @(negedge clk_sys);
    assert (!core_reset_n && !mem_we && !mem_re) else abort_run("bad state after reset");
    assert (rom_mask == '0 && ram_mask == '0) else abort_run("masks not zero after reset");
    for (int n = 0; n < NUM_LOADS; n++) begin
      run_load();
      run_core_ops();
    end
    if (err_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1, "errors found");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
    $display("ERROR: watchdog expired, the run is stuck");
    $display("Testbench failed");
    $fatal(1, "timeout");
  end

endmodule

//--- src.f
verilog/snes_load_pkg.sv
verilog/cart_load_tracker.sv
verilog/ram_clearer.sv
verilog/core_gate.sv
verilog/snes_load_ctrl.sv
verification/tb_snes_load_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f src.f --top-module tb_snes_load_ctrl \
  -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && exit 0 || exit 1
